// ==== rtl/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	////////////////////////////////////////////////////////////
	// Instruction fields

	typedef logic [7:0] byteT;        // Instruction or operand byte
	typedef logic [4:0] opcodeT;
	typedef logic [2:0] modeT;
	typedef logic [2:0] aluOpT;
	typedef logic [2:0] shiftCountT;

	localparam opcodeT OP_ADD    = 5'b00000;
	localparam opcodeT OP_SUB    = 5'b00001;
	localparam opcodeT OP_OR     = 5'b00011;
	localparam opcodeT OP_AND    = 5'b00100;
	localparam opcodeT OP_SHFT   = 5'b00101;
	localparam opcodeT OP_LOAD   = 5'b01010;
	localparam opcodeT OP_INPUT  = 5'b01100;
	localparam opcodeT OP_OUTPUT = 5'b01101;
	localparam opcodeT OP_NOP    = 5'b01111;

	localparam modeT MODE_DIR = 3'b000;   // Direct
	localparam modeT MODE_IND = 3'b001;   // Indirect
	localparam modeT MODE_IMM = 3'b010;   // Immediate

	// Bit 0 is the fill value, bit 1 selects right
	localparam modeT SH_LS0 = 3'b000;
	localparam modeT SH_LS1 = 3'b001;
	localparam modeT SH_RS0 = 3'b010;
	localparam modeT SH_RS1 = 3'b011;

	localparam aluOpT ALU_ADD   = 3'd0;
	localparam aluOpT ALU_SUB   = 3'd1;
	localparam aluOpT ALU_OR    = 3'd2;
	localparam aluOpT ALU_AND   = 3'd3;
	localparam aluOpT ALU_PASS  = 3'd4;   // LOAD and INPUT
	localparam aluOpT ALU_SHIFT = 3'd5;

	////////////////////////////////////////////////////////////
	// Controller states

	typedef enum logic [4:0] {
		sIdle,
		sNop,
		sAddr,
		sAddrWait,
		sRead,
		sOperand,
		sPtrAddr,
		sPtrWait,
		sPtrRead,
		sPtrLatch,
		sImm,
		sExec,
		sShiftSetup,
		sShift,
		sInWait,
		sInCapture,
		sInAck,
		sOutWait,
		sOutSend,
		sOutAck
	} stateT;

endpackage

`default_nettype wire

// ==== rtl/opcodeDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module opcodeDecoder
	import ctrlPkg::*;
(
	input wire clk,
	input wire reset,
	input wire accept,
	input wire byteT instr,
	output stateT entryState,
	output logic legal,
	output aluOpT aluOp
);

	opcodeT opcode;
	modeT mode;
	stateT operandState;
	logic operandLegal;
	aluOpT nextOp;

	assign opcode = instr[7:3];
	assign mode = instr[2:0];

	// Operand fetch path shared by the ALU ops and LOAD
	always_comb begin
		operandState = sIdle;
		operandLegal = 1'b1;
		case (mode)
			MODE_DIR: operandState = sAddr;
			MODE_IND: operandState = sPtrAddr;
			MODE_IMM: operandState = sImm;
			default: operandLegal = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Dispatch

	always_comb begin
		entryState = sIdle;
		legal = 1'b0;
		nextOp = ALU_PASS;
		case (opcode)
			OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD: begin
				entryState = operandState;
				legal = operandLegal;
			end
			OP_SHFT: begin
				entryState = sShiftSetup;
				legal = mode inside {SH_LS0, SH_LS1, SH_RS0, SH_RS1};
			end
			OP_INPUT: begin
				entryState = sInWait;
				legal = 1'b1;
			end
			OP_OUTPUT: begin
				entryState = sOutWait;
				legal = 1'b1;
			end
			OP_NOP: begin
				entryState = sNop;
				legal = 1'b1;
			end
			default: legal = 1'b0;   // Stays idle
		endcase

		case (opcode)
			OP_ADD: nextOp = ALU_ADD;
			OP_SUB: nextOp = ALU_SUB;
			OP_OR: nextOp = ALU_OR;
			OP_AND: nextOp = ALU_AND;
			OP_SHFT: nextOp = ALU_SHIFT;
			default: nextOp = ALU_PASS;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			aluOp <= ALU_PASS;
		end else if (accept) begin
			aluOp <= nextOp;   // Held for the whole instruction
		end
	end

	acceptLegal: assert property (@(posedge clk) disable iff (reset)
		accept |-> legal);

endmodule

`default_nettype wire

// ==== rtl/controlSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlSequencer
	import ctrlPkg::*;
(
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire legal,
	input wire inputRdy,
	input wire outDevRdy,
	input wire outRecv,
	input wire stateT entryState,
	output logic accept,
	output stateT state
);

	stateT nextState;
	logic armed;

	// Second valid cycle in idle takes the instruction
	assign accept = (state == sIdle) && armed && instrValid;

	////////////////////////////////////////////////////////////
	// Arm flag

	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
		end else begin
			armed <= (state == sIdle) && instrValid && legal && !armed;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state

	always_comb begin
		nextState = state;
		case (state)
			sIdle: begin
				if (accept) begin
					nextState = entryState;
				end
			end
			sNop: nextState = sIdle;

			// Pointer fetch, then falls into the direct path
			sPtrAddr: nextState = sPtrWait;
			sPtrWait: nextState = sPtrRead;
			sPtrRead: nextState = sPtrLatch;
			sPtrLatch: nextState = sAddr;

			sAddr: nextState = sAddrWait;
			sAddrWait: nextState = sRead;
			sRead: nextState = sOperand;
			sOperand: nextState = sExec;

			sImm: nextState = sExec;
			sExec: nextState = sIdle;

			sShiftSetup: nextState = sShift;
			sShift: nextState = sIdle;

			sInWait: begin
				if (inputRdy) begin
					nextState = sInCapture;
				end
			end
			sInCapture: nextState = sInAck;
			sInAck: begin
				if (!inputRdy) begin   // Device dropped its ready
					nextState = sIdle;
				end
			end

			sOutWait: begin
				if (outDevRdy) begin
					nextState = sOutSend;
				end
			end
			sOutSend: nextState = sOutAck;
			sOutAck: begin
				if (outRecv) begin
					nextState = sIdle;
				end else begin
					nextState = sOutSend;   // Write again
				end
			end

			default: nextState = sIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sIdle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	acceptInIdle: assert property (@(posedge clk) disable iff (reset)
		accept |-> $past(state == sIdle) && $past(instrValid));

	stateKnown: assert property (@(posedge clk) disable iff (reset)
		state inside {sIdle, sNop, sAddr, sAddrWait, sRead, sOperand,
			sPtrAddr, sPtrWait, sPtrRead, sPtrLatch, sImm, sExec,
			sShiftSetup, sShift, sInWait, sInCapture, sInAck,
			sOutWait, sOutSend, sOutAck});

endmodule

`default_nettype wire

// ==== rtl/controlEncoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlEncoder
	import ctrlPkg::*;
(
	input wire clk,
	input wire reset,
	input wire stateT state,
	input wire byteT instr,
	input wire byteT irData,
	output logic stageIdle,
	output logic memRead,
	output logic indirect,
	output logic accLoad,
	output logic inputRecv,
	output logic outputWrite,
	output shiftCountT shiftCount,
	output logic shiftRight,
	output logic shiftFill
);

	modeT mode;

	assign mode = instr[2:0];

	////////////////////////////////////////////////////////////
	// Control levels

	assign stageIdle = (state == sIdle);
	assign memRead = (state == sRead) || (state == sPtrRead);
	assign indirect = state inside {sPtrAddr, sPtrWait, sPtrRead, sPtrLatch};
	assign accLoad = state inside {sExec, sShift, sInCapture};
	assign inputRecv = (state == sInAck);   // Held until inputRdy falls
	assign outputWrite = (state == sOutSend);

	// Shifter setup, ready by the time sShift loads
	always_ff @(posedge clk) begin
		if (reset) begin
			shiftCount <= '0;
			shiftRight <= 1'b0;
			shiftFill <= 1'b0;
		end else if (state == sShiftSetup) begin
			shiftCount <= irData[2:0];
			shiftRight <= mode[1];
			shiftFill <= mode[0];
		end
	end

	busExclusive: assert property (@(posedge clk) disable iff (reset)
		!(memRead && outputWrite));

endmodule

`default_nettype wire

// ==== rtl/stageOneController.sv ====
`timescale 1ns/1ns
`default_nettype none

module stageOneController
	import ctrlPkg::*;
(
	input wire clk,
	input wire reset,
	input wire byteT instr,
	input wire instrValid,
	input wire byteT irData,
	input wire inputRdy,
	input wire outDevRdy,
	input wire outRecv,
	output logic stageIdle,
	output logic memRead,
	output logic indirect,
	output logic accLoad,
	output aluOpT aluOp,
	output shiftCountT shiftCount,
	output logic shiftRight,
	output logic shiftFill,
	output logic inputRecv,
	output logic outputWrite
);

	stateT entryState;
	stateT state;
	logic legal;
	logic accept;

	opcodeDecoder i_decode (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.instr(instr),
		.entryState(entryState),
		.legal(legal),
		.aluOp(aluOp)
	);

	controlSequencer i_execute (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.legal(legal),
		.inputRdy(inputRdy),
		.outDevRdy(outDevRdy),
		.outRecv(outRecv),
		.entryState(entryState),
		.accept(accept),
		.state(state)
	);

	controlEncoder i_result (
		.clk(clk),
		.reset(reset),
		.state(state),
		.instr(instr),
		.irData(irData),
		.stageIdle(stageIdle),
		.memRead(memRead),
		.indirect(indirect),
		.accLoad(accLoad),
		.inputRecv(inputRecv),
		.outputWrite(outputWrite),
		.shiftCount(shiftCount),
		.shiftRight(shiftRight),
		.shiftFill(shiftFill)
	);

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/tbStageOne.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbStageOne
	import ctrlPkg::*;
();

	localparam int RUNS = 80;
	localparam int WAIT_LIMIT = 200;
	localparam int K_ALU = 0;
	localparam int K_SHIFT = 1;
	localparam int K_INPUT = 2;
	localparam int K_OUTPUT = 3;
	localparam int K_NOP = 4;
	localparam int K_ILLEGAL = 5;

	logic clk;
	logic reset;
	byteT instr;
	logic instrValid;
	byteT irData;
	logic inputRdy;
	logic outDevRdy;
	logic outRecv;
	logic stageIdle;
	logic memRead;
	logic indirect;
	logic accLoad;
	aluOpT aluOp;
	shiftCountT shiftCount;
	logic shiftRight;
	logic shiftFill;
	logic inputRecv;
	logic outputWrite;
	logic [8:0] controls;
	logic [5:0] quietBits;

	// Expected behavior of the instruction in flight
	int kind;
	logic running;
	logic expLegal;
	aluOpT expOp;
	int expLow;
	int expReads;
	int expLoads;
	shiftCountT expCount;
	logic [1:0] expDir;

	int lowCount;
	int readCount;
	int loadCount;
	int mismatches;
	int timeouts;
	logic [31:0] seed = 32'hfb69_e0e2;

	clockGen i_clock (
		.clk(clk),
		.reset(reset)
	);

	stageOneController i_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.irData(irData),
		.inputRdy(inputRdy),
		.outDevRdy(outDevRdy),
		.outRecv(outRecv),
		.stageIdle(stageIdle),
		.memRead(memRead),
		.indirect(indirect),
		.accLoad(accLoad),
		.aluOp(aluOp),
		.shiftCount(shiftCount),
		.shiftRight(shiftRight),
		.shiftFill(shiftFill),
		.inputRecv(inputRecv),
		.outputWrite(outputWrite)
	);

	assign controls = {stageIdle, memRead, indirect, accLoad, inputRecv,
		outputWrite, shiftCount};
	assign quietBits = {i_dut.accept, stageIdle, memRead, accLoad,
		inputRecv, outputWrite};

	function automatic int unsigned randBelow(input int unsigned n);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return (seed >> 16) % n;
	endfunction

	function automatic logic watched(input int sel);
		case (sel)
			0: return stageIdle;
			1: return inputRecv;
			default: return reset;
		endcase
	endfunction

	// Cycles low, reads and loads of the current instruction
	always @(posedge clk) begin
		if (reset || stageIdle) begin
			lowCount <= 0;
			readCount <= 0;
			loadCount <= 0;
		end else begin
			lowCount <= lowCount + 1;
			if (memRead) begin
				readCount <= readCount + 1;
			end
			if (accLoad) begin
				loadCount <= loadCount + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	quietAfterReset: assert property (@(posedge clk) disable iff (reset)
		!running |-> controls == 9'h100)
		else begin
			mismatches++;
			$display("mismatch controls: got %h, expected 100", $sampled(controls));
		end
	aluOpOnLoad: assert property (@(posedge clk) disable iff (reset)
		accLoad |-> aluOp == expOp)
		else begin
			mismatches++;
			$display("mismatch aluOp: got %h, expected %h", $sampled(aluOp), $sampled(expOp));
		end
	busyCycles: assert property (@(posedge clk) disable iff (reset)
		stageIdle && !$past(stageIdle) && expLow != 0 |-> lowCount == expLow)
		else begin
			mismatches++;
			$display("mismatch stageIdle low cycles: got %h, expected %h",
				$sampled(lowCount), $sampled(expLow));
		end
	readCycles: assert property (@(posedge clk) disable iff (reset)
		stageIdle && !$past(stageIdle) && expLow != 0 |-> readCount == expReads)
		else begin
			mismatches++;
			$display("mismatch memRead cycles: got %h, expected %h",
				$sampled(readCount), $sampled(expReads));
		end
	loadCycles: assert property (@(posedge clk) disable iff (reset)
		stageIdle && !$past(stageIdle) && expLow != 0 |-> loadCount == expLoads)
		else begin
			mismatches++;
			$display("mismatch accLoad cycles: got %h, expected %h",
				$sampled(loadCount), $sampled(expLoads));
		end
	shiftAmount: assert property (@(posedge clk) disable iff (reset)
		accLoad && kind == K_SHIFT |-> shiftCount == expCount)
		else begin
			mismatches++;
			$display("mismatch shiftCount: got %h, expected %h",
				$sampled(shiftCount), $sampled(expCount));
		end
	shiftMode: assert property (@(posedge clk) disable iff (reset)
		accLoad && kind == K_SHIFT |-> {shiftRight, shiftFill} == expDir)
		else begin
			mismatches++;
			$display("mismatch {shiftRight,shiftFill}: got %h, expected %h",
				$sampled({shiftRight, shiftFill}), $sampled(expDir));
		end
	inputOrder: assert property (@(posedge clk) disable iff (reset)
		accLoad && kind == K_INPUT |-> $past(inputRdy))
		else begin
			mismatches++;
			$display("input capture happened before inputRdy was high");
		end
	inputHold: assert property (@(posedge clk) disable iff (reset)
		$past(inputRecv) && $past(inputRdy) |-> inputRecv)
		else begin
			mismatches++;
			$display("mismatch inputRecv: got %h, expected 1", $sampled(inputRecv));
		end
	inputDone: assert property (@(posedge clk) disable iff (reset)
		$past(inputRecv) && !$past(inputRdy) |-> stageIdle)
		else begin
			mismatches++;
			$display("mismatch stageIdle: got %h, expected 1", $sampled(stageIdle));
		end
	outputReady: assert property (@(posedge clk) disable iff (reset)
		outputWrite |-> outDevRdy)
		else begin
			mismatches++;
			$display("outputWrite pulsed while outDevRdy was low");
		end
	outputRepeat: assert property (@(posedge clk) disable iff (reset)
		$past(outputWrite) && !outRecv |=> outputWrite)
		else begin
			mismatches++;
			$display("mismatch outputWrite: got %h, expected 1", $sampled(outputWrite));
		end
	outputDone: assert property (@(posedge clk) disable iff (reset)
		$past(outputWrite) && outRecv |=> stageIdle)
		else begin
			mismatches++;
			$display("mismatch stageIdle: got %h, expected 1", $sampled(stageIdle));
		end
	illegalQuiet: assert property (@(posedge clk) disable iff (reset)
		!expLegal |-> quietBits == 6'h10)
		else begin
			mismatches++;
			$display("mismatch %s: got %h, expected 10",
				"{accept,stageIdle,memRead,accLoad,inputRecv,outputWrite}",
				$sampled(quietBits));
		end

	////////////////////////////////////////////////////////////
	// Stimulus

	task automatic waitUntil(input int sel, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (watched(sel) !== level && timeouts == 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timed out waiting for %s", what);
				timeouts++;
			end
		end
	endtask

	task automatic runOne(input int sel);
		opcodeT op;
		modeT mode;
		int writes;
		int target;
		int cycles;
		mode = modeT'(randBelow(3));
		irData = byteT'(randBelow(256));
		expLegal = 1'b1;
		expLow = 0;
		expReads = 0;
		expLoads = 1;
		expOp = ALU_PASS;   // LOAD and INPUT
		case (sel)
			0: begin
				op = OP_ADD;
				expOp = ALU_ADD;
			end
			1: begin
				op = OP_SUB;
				expOp = ALU_SUB;
			end
			2: begin
				op = OP_OR;
				expOp = ALU_OR;
			end
			3: begin
				op = OP_AND;
				expOp = ALU_AND;
			end
			4: op = OP_LOAD;
			5: begin
				op = OP_SHFT;
				expOp = ALU_SHIFT;
			end
			6: op = OP_INPUT;
			7: op = OP_OUTPUT;
			8: op = OP_NOP;
			default: op = (randBelow(2) == 0) ? 5'b10110 : OP_SHFT;
		endcase
		case (sel)
			0, 1, 2, 3, 4: begin
				kind = K_ALU;
				expLow = (mode == MODE_IMM) ? 2 : (mode == MODE_DIR) ? 5 : 9;
				expReads = (mode == MODE_IMM) ? 0 : (mode == MODE_DIR) ? 1 : 2;
			end
			5: begin
				kind = K_SHIFT;
				mode = modeT'(randBelow(4));
				expLow = 2;
				expCount = irData[2:0];
				expDir = mode[1:0];
			end
			6: kind = K_INPUT;
			7: kind = K_OUTPUT;
			8: begin
				kind = K_NOP;
				expLow = 1;
				expLoads = 0;
			end
			default: begin
				kind = K_ILLEGAL;
				expLegal = 1'b0;
				mode = modeT'(4 + randBelow(4));   // No opcode takes these modes
			end
		endcase
		instr = {op, mode};
		instrValid = 1'b1;
		if (kind == K_ILLEGAL) begin
			repeat (4) @(negedge clk);
		end else begin
			waitUntil(0, 1'b0, "stageIdle to fall");
			if (kind == K_INPUT) begin
				repeat (randBelow(4)) @(negedge clk);
				inputRdy = 1'b1;
				waitUntil(1, 1'b1, "inputRecv");
				repeat (randBelow(4)) @(negedge clk);
				inputRdy = 1'b0;
			end else if (kind == K_OUTPUT) begin
				repeat (randBelow(4)) @(negedge clk);
				outDevRdy = 1'b1;
				target = randBelow(3) + 1;   // Writes before the device takes one
				writes = 0;
				cycles = 0;
				while (!stageIdle && timeouts == 0) begin
					@(negedge clk);
					if (outputWrite) begin
						writes++;
						if (writes == target) begin
							outRecv = 1'b1;
						end
					end
					cycles++;
					if (cycles > WAIT_LIMIT) begin
						$display("timed out waiting for the output device handshake");
						timeouts++;
					end
				end
			end
			waitUntil(0, 1'b1, "stageIdle to rise");
		end
		instrValid = 1'b0;
		inputRdy = 1'b0;
		outDevRdy = 1'b0;
		outRecv = 1'b0;
		@(negedge clk);   // Bubble
	endtask

	initial begin
		instr = '0;
		instrValid = 1'b0;
		irData = '0;
		inputRdy = 1'b0;
		outDevRdy = 1'b0;
		outRecv = 1'b0;
		kind = K_NOP;
		running = 1'b0;
		expLegal = 1'b1;
		expOp = ALU_PASS;
		expLow = 0;
		expReads = 0;
		expLoads = 0;
		expCount = '0;
		expDir = '0;
		mismatches = 0;
		timeouts = 0;
		waitUntil(2, 1'b0, "reset release");
		repeat (4) @(negedge clk);
		running = 1'b1;
		for (int n = 0; n < RUNS && timeouts == 0; n++) begin
			runOne(n % 10);
		end
		repeat (2) @(negedge clk);
		$display("mismatches %0d, timeouts %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/ctrlPkg.sv
rtl/opcodeDecoder.sv
rtl/controlSequencer.sv
rtl/controlEncoder.sv
rtl/stageOneController.sv
sim/clockGen.sv
sim/tbStageOne.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbStageOne -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VtbStageOne)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
